//--- dv/cart_tests.txt
# name rom_writable sram_enabled save_offset op host_address count words
# op: T write then read, W write, R read, F random write, C read model, N no oe, H host reset
rom_burst     1 0 00000000 T 10000100 4 1234 5678 9abc def0
rom_protected 0 0 00000000 W 10000100 2 dead beef
rom_keep      0 0 00000000 R 10000100 4 1234 5678 9abc def0
sram_write    0 1 00000200 W 08000010 3 a5a5 5a5a 0f0f
sram_alias    0 1 00000200 R 10000210 3 a5a5 5a5a 0f0f
sram_hi_bit   0 1 00000200 N 08008010 2
sram_off      0 0 00000200 N 08000010 2
fill_a        1 0 00000000 F 10000400 8
fill_b        1 0 00000000 F 10000800 4
long_burst    0 0 00000000 C 10000400 7
new_address   0 0 00000000 C 10000800 4
reset_burst   0 0 00000000 H 10000400 2
after_reset   0 0 00000000 C 10000400 5

//--- dv/tb_cart.sv
`include "cart_defs.svh"

module tb_cart;

    localparam int FIFO_DEPTH = 4;
    localparam int MEM_WORDS = 4096;
    localparam int MEM_LATENCY = 2;
    localparam int MAX_WORDS = 16;
    localparam int OE_TIMEOUT = 32;

    logic sys = 1'b0;
    logic reset;
    logic host_reset;
    logic pi_aleh;
    logic pi_alel;
    logic pi_read;
    logic pi_write;
    logic [15:0] pi_ad_in;
    logic [15:0] pi_ad_out;
    logic pi_ad_oe;
    cart_pkg::cart_cfg_t cfg;

    logic [15:0] shadow [MEM_WORDS];  // expected memory contents
    logic [15:0] words [MAX_WORDS];
    logic [15:0] lfsr_state;
    logic oe_quiet;  // pi_ad_oe must stay low
    int test_errors;

    cart_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) UUT (
        .sys        (sys),
        .reset      (reset),
        .host_reset (host_reset),
        .pi_aleh    (pi_aleh),
        .pi_alel    (pi_alel),
        .pi_read    (pi_read),
        .pi_write   (pi_write),
        .pi_ad_in   (pi_ad_in),
        .pi_ad_out  (pi_ad_out),
        .pi_ad_oe   (pi_ad_oe),
        .cfg        (cfg)
    );

    initial begin
        forever #4 sys = ~sys;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic random_word(output logic [15:0] value);
        value = '0;
        for (int b = 0; b < 16; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[14:0], lfsr_state[0]};
        end
    endtask

    // word index of a host address or -1 for no region
    function automatic int model_index(input logic [31:0] host_addr,
                                       input cart_pkg::cart_cfg_t c);
        logic [15:0] hi;
        logic [15:0] lo;
        logic [31:0] internal;
        hi = host_addr[31:16];
        lo = host_addr[15:0];
        if (hi >= `ROM_HI_FIRST && hi <= `ROM_HI_LAST) begin
            internal = host_addr - {`ROM_HI_FIRST, 16'h0000};
        end else if (c.sram_enabled && hi == `SRAM_HI && !lo[15]) begin
            internal = c.save_offset + `SRAM_BASE + {16'h0000, lo};
        end else begin
            return -1;
        end
        return int'(internal[31:1]) % MEM_WORDS;
    endfunction

    function automatic logic write_lands(input logic [31:0] host_addr,
                                         input cart_pkg::cart_cfg_t c);
        logic rom;
        rom = host_addr[31:16] >= `ROM_HI_FIRST && host_addr[31:16] <= `ROM_HI_LAST;
        return model_index(host_addr, c) >= 0 && (!rom || c.rom_writable);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic tick(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge sys);
            if (oe_quiet) begin
                assert (pi_ad_oe === 1'b0) else begin
                    $display("ERROR at %0t: pi_ad_oe expected 0, got %b", $time, pi_ad_oe);
                    test_errors++;
                end
            end
        end
    endtask

    task automatic send_address(input logic [31:0] addr);
        pi_ad_in = addr[31:16];
        pi_alel = 1'b1;  // upper half
        tick(8);
        pi_ad_in = addr[15:0];
        pi_aleh = 1'b0;  // lower half
        tick(8);
        pi_ad_in = '0;
        pi_alel = 1'b0;  // data phase
        tick(8);
    endtask

    task automatic end_access();
        pi_aleh = 1'b1;
        tick(16);  // lets the write fifo drain
    endtask

    task automatic write_word(input logic [15:0] value);
        pi_ad_in = value;
        pi_write = 1'b0;
        tick(16);
        pi_write = 1'b1;
        tick(8);
    endtask

    task automatic read_word(input logic [15:0] expected);
        int waited;
        waited = 0;
        pi_read = 1'b0;
        while (pi_ad_oe !== 1'b1 && waited < OE_TIMEOUT) begin
            tick(1);
            waited++;
        end
        if (waited < 16) tick(16 - waited);
        if (pi_ad_oe !== 1'b1) begin
            $display("output enable did not rise within %0d cycles of the read strobe",
                     OE_TIMEOUT);
            test_errors++;
        end else begin
            assert (pi_ad_out === expected) else begin
                $display("ERROR at %0t: pi_ad_out expected %h, got %h",
                         $time, expected, pi_ad_out);
                test_errors++;
            end
        end
        pi_read = 1'b1;
        tick(8);
    endtask

    task automatic strobe_read();
        pi_read = 1'b0;
        tick(16);
        pi_read = 1'b1;
        tick(8);
    endtask

    task automatic run_test(input logic [7:0] op, input logic [31:0] addr, input int count);
        int base;
        logic [15:0] value;
        base = model_index(addr, cfg);
        case (op)
            "T", "W", "F": begin
                send_address(addr);
                for (int k = 0; k < count; k++) begin
                    if (op == "F") begin
                        random_word(value);
                        words[k] = value;
                    end
                    write_word(words[k]);
                end
                end_access();
                if (write_lands(addr, cfg)) begin
                    for (int k = 0; k < count; k++) begin
                        shadow[(base + k) % MEM_WORDS] = words[k];
                    end
                end
                if (op == "T") begin
                    send_address(addr);
                    for (int k = 0; k < count; k++) read_word(words[k]);
                    end_access();
                end
            end
            "R": begin
                send_address(addr);
                for (int k = 0; k < count; k++) read_word(words[k]);
                end_access();
            end
            "C", "H": begin
                if (base < 0) begin
                    $display("address %h maps to no region, nothing to compare", addr);
                    test_errors++;
                end else begin
                    send_address(addr);
                    for (int k = 0; k < count; k++) read_word(shadow[(base + k) % MEM_WORDS]);
                    if (op == "H") begin
                        pi_read = 1'b0;
                        tick(12);
                        host_reset = 1'b1;  // console reset mid burst
                        tick(1);
                        oe_quiet = 1'b1;
                        tick(10);
                        oe_quiet = 1'b0;
                        host_reset = 1'b0;
                        pi_read = 1'b1;
                        tick(8);
                    end
                    end_access();
                end
            end
            "N": begin
                oe_quiet = 1'b1;
                send_address(addr);
                for (int k = 0; k < count; k++) strobe_read();
                end_access();
                oe_quiet = 1'b0;
            end
            default: begin
                $display("unknown operation %s in the test file", op);
                test_errors++;
            end
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int fd;
        int code;
        int count;
        int tests_run;
        int tests_failed;
        logic file_ok;
        logic words_ok;
        logic [8*32-1:0] name;
        logic [8*256-1:0] rest;
        logic [8*8-1:0] op_text;
        logic [31:0] rom_wr;
        logic [31:0] sram_en;
        logic [31:0] offset;
        logic [31:0] addr;
        logic [15:0] value;

        reset = 1'b1;
        host_reset = 1'b1;
        pi_aleh = 1'b1;  // idle
        pi_alel = 1'b0;
        pi_read = 1'b1;
        pi_write = 1'b1;
        pi_ad_in = '0;
        cfg = '0;
        oe_quiet = 1'b0;
        lfsr_state = 16'd30;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int i = 0; i < MEM_WORDS; i++) shadow[i] = 16'h0000;

        tick(10);
        reset = 1'b0;
        host_reset = 1'b0;
        tick(8);

        fd = $fopen("dv/cart_tests.txt", "r");
        file_ok = (fd != 0);
        if (!file_ok) $display("could not open dv/cart_tests.txt");
        while (file_ok && $fscanf(fd, "%s", name) == 1) begin
            if (name[7:0] == "#" && name[255:8] == '0) begin
                code = $fgets(rest, fd);  // comment line
            end else begin
                code = $fscanf(fd, "%h %h %h %s %h %d",
                               rom_wr, sram_en, offset, op_text, addr, count);
                words_ok = (code == 6 && count <= MAX_WORDS);
                // F, C, N and H lines list no words
                if (words_ok && (op_text[7:0] == "T" || op_text[7:0] == "W"
                                 || op_text[7:0] == "R")) begin
                    for (int k = 0; k < count; k++) begin
                        code = $fscanf(fd, "%h", value);
                        if (code != 1) words_ok = 1'b0;
                        words[k] = value;
                    end
                end
                if (!words_ok) begin
                    $display("malformed test line %0s in the test file", name);
                    file_ok = 1'b0;
                end else begin
                    cfg.rom_writable = rom_wr[0];
                    cfg.sram_enabled = sram_en[0];
                    cfg.save_offset = offset;
                    test_errors = 0;
                    run_test(op_text[7:0], addr, count);
                    tests_run++;
                    if (test_errors == 0) begin
                        $display("test %0s: ok", name);
                    end else begin
                        $display("test %0s: fail, %0d errors", name, test_errors);
                        tests_failed++;
                    end
                end
            end
        end
        if (fd != 0) $fclose(fd);

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (file_ok && tests_run > 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- include/cart_defs.svh
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// upper address halves on the PI bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define ROM_HI_FIRST 16'h1000  // first ROM window half
`define ROM_HI_LAST 16'h13FF   // last ROM window half
`define SRAM_HI 16'h0800       // unbanked save window

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// internal memory layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SRAM_BASE 32'h0800_0000  // save area, before save_offset

`endif

//--- rtl/cart_memory.sv
module cart_memory #(
    parameter int MEM_WORDS = 4096,
    parameter int MEM_LATENCY = 2
) (
    input  logic                sys,
    input  logic                reset,
    input  cart_pkg::cart_req_t mem_req,
    output cart_pkg::cart_rsp_t mem_rsp
);

    localparam int INDEX_W = $clog2(MEM_WORDS);
    localparam int COUNT_W = $clog2(MEM_LATENCY + 1);

    logic [15:0] mem [MEM_WORDS];
    logic [INDEX_W-1:0] index;
    logic [COUNT_W-1:0] count;
    logic [COUNT_W-1:0] next_count;
    logic busy;
    logic selected;
    logic done;
    logic ack_q;
    logic [15:0] rdata_q;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 16'h0000;
        end
    end

    assign index = mem_req.address[INDEX_W:1];  // wraps at MEM_WORDS

    // other targets never get an ack
    assign selected = mem_req.request && mem_req.target == cart_pkg::TARGET_MEM && !ack_q;
    assign next_count = busy ? count + 1'b1 : COUNT_W'(1);
    assign done = selected && next_count == COUNT_W'(MEM_LATENCY);

    assign mem_rsp = '{ack: ack_q, rdata: rdata_q};

    always_ff @(posedge sys) begin
        if (reset) begin
            busy <= 1'b0;
            count <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= done;
            busy <= selected && !done;  // drops if request goes away
            if (selected) count <= next_count;
        end
    end

    always_ff @(posedge sys) begin
        if (done) begin
            if (mem_req.write) begin
                mem[index] <= mem_req.wdata;
            end else begin
                rdata_q <= mem[index];
            end
        end
    end

endmodule

//--- rtl/cart_pkg.sv
package cart_pkg;

    // internal bus targets, room left for more
    typedef enum logic [1:0] {
        TARGET_NONE = 2'd0,
        TARGET_MEM  = 2'd1
    } cart_target_e;

    // bus phase as {aleh, alel}
    typedef enum logic [1:0] {
        PI_MODE_IDLE  = 2'b10,
        PI_MODE_HIGH  = 2'b11,
        PI_MODE_LOW   = 2'b01,
        PI_MODE_VALID = 2'b00
    } pi_mode_e;

    // bridge to memory
    typedef struct packed {
        logic         request;
        logic         write;
        cart_target_e target;
        logic [31:0]  address;  // byte address, always even
        logic [15:0]  wdata;
    } cart_req_t;

    // memory to bridge
    typedef struct packed {
        logic        ack;
        logic [15:0] rdata;  // valid with ack on reads
    } cart_rsp_t;

    typedef struct packed {
        logic        rom_writable;
        logic        sram_enabled;
        logic [31:0] save_offset;
    } cart_cfg_t;

endpackage

//--- rtl/cart_top.sv
module cart_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int MEM_WORDS = 4096,
    parameter int MEM_LATENCY = 2
) (
    input  logic                sys,
    input  logic                reset,
    input  logic                host_reset,  // console hard reset
    input  logic                pi_aleh,
    input  logic                pi_alel,
    input  logic                pi_read,     // active low
    input  logic                pi_write,    // active low
    input  logic [15:0]         pi_ad_in,
    output logic [15:0]         pi_ad_out,
    output logic                pi_ad_oe,
    input  cart_pkg::cart_cfg_t cfg
);

    cart_pkg::cart_req_t mem_req;
    cart_pkg::cart_rsp_t mem_rsp;

    pi_bus_bridge #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) bridge_inst (
        .sys        (sys),
        .reset      (reset),
        .host_reset (host_reset),
        .pi_aleh    (pi_aleh),
        .pi_alel    (pi_alel),
        .pi_read    (pi_read),
        .pi_write   (pi_write),
        .pi_ad_in   (pi_ad_in),
        .cfg        (cfg),
        .mem_rsp    (mem_rsp),
        .pi_ad_out  (pi_ad_out),
        .pi_ad_oe   (pi_ad_oe),
        .mem_req    (mem_req)
    );

    cart_memory #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) memory_inst (
        .sys     (sys),
        .reset   (reset),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

//--- rtl/pi_bus_bridge.sv
`include "cart_defs.svh"

module pi_bus_bridge #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  sys,
    input  logic                  reset,
    input  logic                  host_reset,
    input  logic                  pi_aleh,
    input  logic                  pi_alel,
    input  logic                  pi_read,
    input  logic                  pi_write,
    input  logic [15:0]           pi_ad_in,
    input  cart_pkg::cart_cfg_t   cfg,
    input  cart_pkg::cart_rsp_t   mem_rsp,
    output logic [15:0]           pi_ad_out,
    output logic                  pi_ad_oe,
    output cart_pkg::cart_req_t   mem_req
);

    typedef struct packed {
        logic aleh;
        logic alel;
        logic read;
        logic write;
    } strobes_t;

    logic bridge_reset;

    assign bridge_reset = reset || host_reset;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fifos
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic read_fifo_flush;
    logic read_fifo_write;
    logic read_fifo_read;
    logic read_fifo_full;
    logic read_fifo_empty;
    logic [15:0] read_fifo_rdata;

    logic write_fifo_flush;
    logic write_fifo_write;
    logic write_fifo_read;
    logic write_fifo_full;
    logic write_fifo_empty;
    logic [15:0] write_fifo_wdata;
    logic [15:0] write_fifo_rdata;

    pi_fifo #(.DEPTH(FIFO_DEPTH)) read_fifo_inst (
        .sys   (sys),
        .reset (reset),
        .flush (read_fifo_flush),
        .write (read_fifo_write),
        .wdata (mem_rsp.rdata),
        .read  (read_fifo_read),
        .full  (read_fifo_full),
        .empty (read_fifo_empty),
        .rdata (read_fifo_rdata)
    );

    pi_fifo #(.DEPTH(FIFO_DEPTH)) write_fifo_inst (
        .sys   (sys),
        .reset (reset),
        .flush (write_fifo_flush),
        .write (write_fifo_write),
        .wdata (write_fifo_wdata),
        .read  (write_fifo_read),
        .full  (write_fifo_full),
        .empty (write_fifo_empty),
        .rdata (write_fifo_rdata)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sync and bus events
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    strobes_t strobe_pins;
    strobes_t [2:0] strobe_ff;
    strobes_t strobe_s;

    assign strobe_pins = '{aleh: pi_aleh, alel: pi_alel, read: pi_read, write: pi_write};
    assign strobe_s = strobe_ff[2];

    always_ff @(posedge sys) begin
        strobe_ff <= {strobe_ff[1:0], strobe_pins};
    end

    cart_pkg::pi_mode_e pi_mode;
    cart_pkg::pi_mode_e last_mode;
    logic last_read;
    logic last_write;

    assign pi_mode = cart_pkg::pi_mode_e'({strobe_s.aleh, strobe_s.alel});

    always_ff @(posedge sys) begin
        last_mode <= pi_mode;
        last_read <= strobe_s.read;
        last_write <= strobe_s.write;
    end

    logic aleh_op;
    logic alel_op;
    logic read_op;
    logic write_op;
    logic end_op;

    always_comb begin
        aleh_op = !bridge_reset && last_mode != cart_pkg::PI_MODE_HIGH
                  && pi_mode == cart_pkg::PI_MODE_HIGH;
        alel_op = !bridge_reset && last_mode == cart_pkg::PI_MODE_HIGH
                  && pi_mode == cart_pkg::PI_MODE_LOW;
        read_op = !bridge_reset && pi_mode == cart_pkg::PI_MODE_VALID
                  && last_read && !strobe_s.read;
        write_op = !bridge_reset && pi_mode == cart_pkg::PI_MODE_VALID
                   && last_write && !strobe_s.write;
        end_op = !bridge_reset && last_mode == cart_pkg::PI_MODE_VALID
                 && pi_mode != cart_pkg::PI_MODE_VALID;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [15:0] ad_input;
    logic address_valid;
    logic sram_selected;
    logic valid_after_alel;
    logic [31:0] start_base;  // added to the even lower half

    always_ff @(posedge sys) begin
        ad_input <= pi_ad_in;
    end

    assign valid_after_alel = address_valid && !(sram_selected && ad_input[15]);

    always_ff @(posedge sys) begin
        if (bridge_reset) begin
            address_valid <= 1'b0;
            sram_selected <= 1'b0;
        end else if (aleh_op) begin
            address_valid <= 1'b0;
            sram_selected <= 1'b0;
            if (ad_input >= `ROM_HI_FIRST && ad_input <= `ROM_HI_LAST) begin
                address_valid <= 1'b1;
                start_base <= {ad_input - `ROM_HI_FIRST, 16'h0000};
            end else if (cfg.sram_enabled && ad_input == `SRAM_HI) begin
                address_valid <= 1'b1;
                sram_selected <= 1'b1;
                start_base <= cfg.save_offset + `SRAM_BASE;
            end
        end else if (alel_op) begin
            address_valid <= valid_after_alel;  // save window is 32k
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data sampling
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic oe_next;
    logic wait_read;
    logic pending_write;
    logic [15:0] write_hold;

    assign oe_next = pi_mode == cart_pkg::PI_MODE_VALID && address_valid && !strobe_s.read;
    assign write_fifo_wdata = write_hold;

    always_ff @(posedge sys) begin
        if (write_op) write_hold <= ad_input;
    end

    always_ff @(posedge sys) begin
        read_fifo_read <= 1'b0;
        write_fifo_write <= 1'b0;
        if (bridge_reset) begin
            pi_ad_oe <= 1'b0;
            wait_read <= 1'b0;
            pending_write <= 1'b0;
        end else begin
            pi_ad_oe <= oe_next;
            if (alel_op) begin
                wait_read <= 1'b0;
            end else if (address_valid && (read_op || wait_read)) begin
                if (read_fifo_empty) begin
                    wait_read <= 1'b1;  // word still on its way
                end else begin
                    pi_ad_out <= read_fifo_rdata;
                    read_fifo_read <= 1'b1;
                    wait_read <= 1'b0;
                end
            end
            if (address_valid && (write_op || pending_write)) begin
                if (write_fifo_full) begin
                    pending_write <= 1'b1;
                end else begin
                    write_fifo_write <= 1'b1;
                    pending_write <= 1'b0;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus controller
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic can_read;
    logic first_write;
    logic load_start;
    logic drop_ack;  // read in flight across a new address
    cart_pkg::cart_target_e start_target;
    logic [31:0] start_address;

    assign read_fifo_write = mem_req.request && !mem_req.write && mem_rsp.ack && !drop_ack;

    always_ff @(posedge sys) begin
        read_fifo_flush <= 1'b0;
        write_fifo_read <= 1'b0;
        if (bridge_reset) begin
            mem_req.request <= 1'b0;
            read_fifo_flush <= 1'b1;
            write_fifo_flush <= 1'b1;
            can_read <= 1'b0;
            first_write <= 1'b0;
            load_start <= 1'b0;
            drop_ack <= 1'b0;
        end else begin
            // protected ROM writes get discarded
            write_fifo_flush <= address_valid && !sram_selected && !cfg.rom_writable;

            if (!mem_req.request) begin
                if (!write_fifo_empty && !write_fifo_flush) begin
                    mem_req.request <= 1'b1;
                    mem_req.write <= 1'b1;
                    mem_req.wdata <= write_fifo_rdata;
                    write_fifo_read <= 1'b1;
                    if (load_start) begin
                        mem_req.target <= start_target;
                        mem_req.address <= start_address;
                        load_start <= 1'b0;
                    end
                end else if (can_read && !read_fifo_full) begin
                    mem_req.request <= 1'b1;
                    mem_req.write <= 1'b0;
                    if (load_start) begin
                        mem_req.target <= start_target;
                        mem_req.address <= start_address;
                        load_start <= 1'b0;
                    end
                end
            end else if (mem_rsp.ack) begin
                mem_req.request <= 1'b0;
                mem_req.address <= mem_req.address + 32'd2;
                drop_ack <= 1'b0;
            end

            // placed after the issue logic so a reload is never lost
            if (alel_op) begin
                read_fifo_flush <= 1'b1;
                can_read <= valid_after_alel;
                first_write <= 1'b1;
                load_start <= 1'b1;
                start_target <= valid_after_alel ? cart_pkg::TARGET_MEM : cart_pkg::TARGET_NONE;
                start_address <= start_base + {16'h0000, ad_input[15:1], 1'b0};
                if (mem_req.request && !mem_rsp.ack) drop_ack <= 1'b1;
            end

            if (write_op) begin
                can_read <= 1'b0;  // prefetch is useless now
                if (first_write) begin
                    first_write <= 1'b0;
                    load_start <= 1'b1;
                end
            end

            if (end_op) can_read <= 1'b0;
        end
    end

endmodule

//--- rtl/pi_fifo.sv
module pi_fifo #(
    parameter int DEPTH = 4
) (
    input  logic        sys,
    input  logic        reset,
    input  logic        flush,
    input  logic        write,
    input  logic [15:0] wdata,
    input  logic        read,
    output logic        full,
    output logic        empty,
    output logic [15:0] rdata
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [15:0] buffer [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_write;
    logic do_read;

    // wraps for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign rdata = buffer[rd_ptr];  // oldest word

    assign do_write = write && !full;  // dropped when full
    assign do_read = read && !empty;

    always_ff @(posedge sys) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) wr_ptr <= next_ptr(wr_ptr);
            if (do_read) rd_ptr <= next_ptr(rd_ptr);
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge sys) begin
        if (do_write) begin
            buffer[wr_ptr] <= wdata;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# builds and runs the cart testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module tb_cart -o sim_cart; then
    echo "verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/sim_cart 2>&1); then
    echo "$out"
    echo "simulation exited with an error"
    exit 1
fi
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

//--- tb.f
+incdir+include
rtl/cart_pkg.sv
rtl/pi_fifo.sv
rtl/pi_bus_bridge.sv
rtl/cart_memory.sv
rtl/cart_top.sv
dv/tb_cart.sv
